// File: verilog/video_core_macros.svh
// raster geometry for the 320x240 test video path
// wishbone register map of the control block
`ifndef VIDEO_CORE_MACROS_SVH
`define VIDEO_CORE_MACROS_SVH

//////////////////////////////////////////////////////////////
// raster timing
//////////////////////////////////////////////////////////////

// clocks per line, total and visible
`define VID_H_TOTAL   400
`define VID_H_ACTIVE  320
// clocks ahead of the first visible pixel
`define VID_H_BPORCH  10

// lines per frame, total and visible
`define VID_V_TOTAL   512
`define VID_V_ACTIVE  240
`define VID_V_BPORCH  10

// line position of the hsync pulse
`define VID_HS_POS    3

// counters and buffer addresses share this width
`define VID_CNT_W     10

//////////////////////////////////////////////////////////////
// register map, byte addresses
//////////////////////////////////////////////////////////////

`define WB_ADR_MODE   0
`define WB_ADR_COLOR  4
`define WB_ADR_FRAMES 8

`endif

// File: verilog/video_core_pkg.sv
// shared types of the video path
// pixel word, pattern mode, sync pulses, video output, wishbone request and response
package video_core_pkg;

    // 24-bit pixel, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pix_t;

    // test pattern selection, 3 falls back to solid
    typedef enum logic [1:0] {
        MODE_SOLID    = 2'd0,
        MODE_BARS     = 2'd1,
        MODE_GRADIENT = 2'd2
    } pattern_mode_t;

    // raster pulses toward the pattern writer and register block
    typedef struct packed {
        logic frame_start;
        logic line_req;
    } video_sync_t;

    // registered video output
    typedef struct packed {
        pix_t rgb;
        logic de;
        logic vs;
        logic hs;
    } vid_out_t;

    // wishbone classic slave side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// File: verilog/video_timing.sv
// raster generator: x/y counters, vs and hs pulses
// line request and frame start pulses for the pattern writer
// line buffer read scheduling and the registered video output
`include "video_core_macros.svh"

module video_timing (
    input  logic                          clk_sdram,
    input  logic                          reset_n,
    output video_core_pkg::video_sync_t   sync,
    output logic                          rd_en,
    output logic [`VID_CNT_W-1:0]         rd_addr,
    input  video_core_pkg::pix_t          rd_data,
    output video_core_pkg::vid_out_t      vid
);

    localparam int CW = `VID_CNT_W;

    localparam logic [CW-1:0] H_LAST   = CW'(`VID_H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST   = CW'(`VID_V_TOTAL - 1);
    localparam logic [CW-1:0] H_FIRST  = CW'(`VID_H_BPORCH);
    localparam logic [CW-1:0] H_END    = CW'(`VID_H_BPORCH + `VID_H_ACTIVE);
    localparam logic [CW-1:0] V_FIRST  = CW'(`VID_V_BPORCH);
    localparam logic [CW-1:0] V_END    = CW'(`VID_V_BPORCH + `VID_V_ACTIVE);
    localparam logic [CW-1:0] HS_AT    = CW'(`VID_HS_POS);
    // two lines of buffer, read address wraps here
    localparam logic [CW-1:0] ADDR_TOP = CW'(2 * `VID_H_ACTIVE - 1);

    logic [CW-1:0] x_count;
    logic [CW-1:0] y_count;

    logic at_origin;
    logic line_active;
    logic pix_active;
    logic rd_window;
    logic req_window;

    assign at_origin   = (x_count == '0) && (y_count == '0);
    assign line_active = (y_count >= V_FIRST) && (y_count < V_END);
    assign pix_active  = line_active && (x_count >= H_FIRST) && (x_count < H_END);
    // setting up rd_en for next cycle, so two ahead of the pixel
    assign rd_window   = line_active && (x_count >= H_FIRST - 2'd2) && (x_count < H_END - 2'd2);
    // line ahead of each visible line
    assign req_window  = (x_count == '0) && (y_count >= V_FIRST - 1'b1) &&
                         (y_count < V_END - 1'b1);

    //////////////////////////////////////////////////////////////
    // raster counters
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else if (x_count == H_LAST) begin
            x_count <= '0;
            // end of frame
            y_count <= (y_count == V_LAST) ? '0 : y_count + 1'b1;
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////
    // pulses, buffer reads, output register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            sync    <= '0;
            rd_en   <= 1'b0;
            rd_addr <= '0;
            vid     <= '0;
        end else begin
            sync.frame_start <= at_origin;
            sync.line_req    <= req_window;
            vid.vs           <= at_origin;
            // hs a few clocks after vs
            vid.hs           <= (x_count == HS_AT);

            rd_en <= rd_window;
            // address moves only after a read really happened
            if (at_origin) begin
                rd_addr <= '0;
            end else if (rd_en) begin
                rd_addr <= (rd_addr == ADDR_TOP) ? '0 : rd_addr + 1'b1;
            end

            // black outside the visible window
            vid.de  <= pix_active;
            vid.rgb <= pix_active ? rd_data : '0;
        end
    end

endmodule

// File: verilog/line_buffer.sv
// two-line pixel memory between the pattern writer and the raster
// wrapping write pointer, cleared every frame
// registered read port
`include "video_core_macros.svh"

module line_buffer (
    input  logic                   clk_sdram,
    input  logic                   reset_n,
    input  logic                   frame_start,
    input  logic                   wr_en,
    input  video_core_pkg::pix_t   wr_data,
    input  logic                   rd_en,
    input  logic [`VID_CNT_W-1:0]  rd_addr,
    output video_core_pkg::pix_t   rd_data
);

    import video_core_pkg::*;

    localparam int DEPTH = 2 * `VID_H_ACTIVE;
    localparam logic [`VID_CNT_W-1:0] PTR_TOP = `VID_CNT_W'(DEPTH - 1);

    // one line shown while the other one fills
    pix_t mem [DEPTH];

    logic [`VID_CNT_W-1:0] wr_ptr;

    //////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
        end else if (frame_start) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            // modulo two lines
            wr_ptr <= (wr_ptr == PTR_TOP) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_sdram) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////

    // data one cycle after rd_en
    always_ff @(posedge clk_sdram) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: verilog/pattern_gen.sv
// test pattern writer: one buffer line per line request
// solid colour, eight colour bars or an x/y gradient
// mode and colour sampled once per frame
`include "video_core_macros.svh"

module pattern_gen (
    input  logic                          clk_sdram,
    input  logic                          reset_n,
    input  video_core_pkg::video_sync_t   sync,
    input  video_core_pkg::pattern_mode_t mode,
    input  video_core_pkg::pix_t          solid_color,
    output logic                          wr_en,
    output video_core_pkg::pix_t          wr_data
);

    import video_core_pkg::*;

    localparam int CW = `VID_CNT_W;
    localparam logic [CW-1:0] PIX_LAST = CW'(`VID_H_ACTIVE - 1);
    // 40 pixels per bar
    localparam logic [5:0]    BAR_LAST = 6'd39;

    pattern_mode_t mode_q;
    pix_t          color_q;

    logic          busy;
    logic [CW-1:0] pix_cnt;
    logic [CW-1:0] line_idx;
    logic [5:0]    bar_pos;
    logic [2:0]    bar_idx;
    pix_t          pix_next;

    // pixel for the current count
    always_comb begin
        case (mode_q)
            MODE_BARS: begin
                pix_next.r = {8{bar_idx[0]}};
                pix_next.g = {8{bar_idx[1]}};
                pix_next.b = {8{bar_idx[2]}};
            end
            MODE_GRADIENT: begin
                pix_next.r = pix_cnt[7:0];
                pix_next.g = line_idx[7:0];
                pix_next.b = 8'h00;
            end
            // solid, also the unused code 3
            default: pix_next = color_q;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // per frame and per line control
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            mode_q   <= MODE_SOLID;
            color_q  <= '0;
            busy     <= 1'b0;
            pix_cnt  <= '0;
            line_idx <= '0;
            bar_pos  <= '0;
            bar_idx  <= '0;
        end else begin
            // new settings apply from frame start only
            if (sync.frame_start) begin
                mode_q  <= mode;
                color_q <= solid_color;
            end

            if (sync.line_req) begin
                busy    <= 1'b1;
                pix_cnt <= '0;
                bar_pos <= '0;
                bar_idx <= '0;
            end else if (busy) begin
                pix_cnt <= pix_cnt + 1'b1;
                // bar position within the current bar
                if (bar_pos == BAR_LAST) begin
                    bar_pos <= '0;
                    bar_idx <= bar_idx + 1'b1;
                end else begin
                    bar_pos <= bar_pos + 1'b1;
                end
                if (pix_cnt == PIX_LAST) begin
                    busy <= 1'b0;
                end
            end

            // visible line counter
            if (sync.frame_start) begin
                line_idx <= '0;
            end else if (busy && pix_cnt == PIX_LAST) begin
                line_idx <= line_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // buffer write port
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= busy;
        end
    end

    always_ff @(posedge clk_sdram) begin
        if (busy) begin
            wr_data <= pix_next;
        end
    end

endmodule

// File: verilog/wb_regs.sv
// wishbone classic slave with single cycle ack
// mode and colour registers, read-only frame counter
`include "video_core_macros.svh"

module wb_regs (
    input  logic                          clk_sdram,
    input  logic                          reset_n,
    input  video_core_pkg::wb_req_t       wb_req,
    output video_core_pkg::wb_rsp_t       wb_rsp,
    input  logic                          frame_start,
    output video_core_pkg::pattern_mode_t mode,
    output video_core_pkg::pix_t          solid_color
);

    import video_core_pkg::*;

    localparam logic [7:0] ADR_MODE   = 8'(`WB_ADR_MODE);
    localparam logic [7:0] ADR_COLOR  = 8'(`WB_ADR_COLOR);
    localparam logic [7:0] ADR_FRAMES = 8'(`WB_ADR_FRAMES);

    logic        req_new;
    logic [31:0] frame_cnt;
    logic [31:0] rd_mux;

    // request seen for the first time, ack cycle blocks a repeat
    assign req_new = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    // read decode, unmapped reads as zero
    always_comb begin
        case (wb_req.adr)
            ADR_MODE:   rd_mux = {30'd0, mode};
            ADR_COLOR:  rd_mux = {8'd0, solid_color};
            ADR_FRAMES: rd_mux = frame_cnt;
            default:    rd_mux = 32'd0;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // bus response and register writes
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            wb_rsp      <= '0;
            mode        <= MODE_SOLID;
            solid_color <= '0;
        end else begin
            wb_rsp.ack <= req_new;
            if (req_new) begin
                wb_rsp.dat <= rd_mux;
            end
            // writes elsewhere are acked and dropped
            if (req_new && wb_req.we) begin
                if (wb_req.adr == ADR_MODE) begin
                    mode <= pattern_mode_t'(wb_req.dat[1:0]);
                end
                if (wb_req.adr == ADR_COLOR) begin
                    solid_color <= wb_req.dat[23:0];
                end
            end
        end
    end

    // frames since reset, free running
    always_ff @(posedge clk_sdram or negedge reset_n) begin
        if (!reset_n) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/video_core.sv
// top of the video path
// register block, raster timing, line buffer and pattern writer
`include "video_core_macros.svh"

module video_core (
    input  logic                     clk_sdram,
    input  logic                     reset_n,
    input  video_core_pkg::wb_req_t  wb_req,
    output video_core_pkg::wb_rsp_t  wb_rsp,
    output video_core_pkg::vid_out_t vid
);

    import video_core_pkg::*;

    // raster pulses
    video_sync_t           sync;

    // buffer read path
    logic                  rd_en;
    logic [`VID_CNT_W-1:0] rd_addr;
    pix_t                  rd_data;

    // buffer write path
    logic                  wr_en;
    pix_t                  wr_data;

    // pattern settings
    pattern_mode_t         mode;
    pix_t                  solid_color;

    wb_regs regs0 (
        .clk_sdram   (clk_sdram),
        .reset_n     (reset_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .frame_start (sync.frame_start),
        .mode        (mode),
        .solid_color (solid_color)
    );

    video_timing timing0 (
        .clk_sdram (clk_sdram),
        .reset_n   (reset_n),
        .sync      (sync),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .vid       (vid)
    );

    line_buffer lbuf0 (
        .clk_sdram   (clk_sdram),
        .reset_n     (reset_n),
        .frame_start (sync.frame_start),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    pattern_gen pgen0 (
        .clk_sdram   (clk_sdram),
        .reset_n     (reset_n),
        .sync        (sync),
        .mode        (mode),
        .solid_color (solid_color),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

endmodule

// File: test/video_core_assert.sv
// concurrent port rules of the video core
// de against vs, single-cycle hs, ack only after a request
module video_core_assert (
    input logic                     clk_sdram,
    input logic                     reset_n,
    input video_core_pkg::wb_req_t  wb_req,
    input video_core_pkg::wb_rsp_t  wb_rsp,
    input video_core_pkg::vid_out_t vid
);

    timeunit 1ns;
    timeprecision 1ns;

    // failures so far, looked at by the testbench at the end
    int fail_count = 0;

    // vs falls in the blanking, never inside the visible window
    de_vs_apart: assert property (@(posedge clk_sdram) disable iff (!reset_n)
        !(vid.de && vid.vs))
        else begin
            $error("de and vs high in the same cycle");
            fail_count++;
        end

    // hs is a single clock wide
    hs_single: assert property (@(posedge clk_sdram) disable iff (!reset_n)
        vid.hs |=> !vid.hs)
        else begin
            $error("hs high for two cycles");
            fail_count++;
        end

    // slave answers, never starts on its own
    ack_after_req: assert property (@(posedge clk_sdram) disable iff (!reset_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without a request in the cycle before");
            fail_count++;
        end

endmodule

// File: test/video_core_tb.sv
// testbench of the video core
// clock, reset, lfsr colours and wishbone access tasks
// table of pattern modes, each checked over one whole frame
`include "video_core_macros.svh"

module video_core_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import video_core_pkg::*;

    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int VS_TIMEOUT   = FRAME_CYCLES + FRAME_CYCLES / 10;
    localparam int ACK_TIMEOUT  = 4;
    localparam int BAR_W        = `VID_H_ACTIVE / 8;
    localparam int ROWS         = 4;

    localparam logic [7:0] ADR_MODE   = 8'(`WB_ADR_MODE);
    localparam logic [7:0] ADR_COLOR  = 8'(`WB_ADR_COLOR);
    localparam logic [7:0] ADR_FRAMES = 8'(`WB_ADR_FRAMES);

    // one table row: mode, and a fixed colour or a random one
    typedef struct packed {
        logic [1:0]  mode;
        logic        rand_color;
        logic [23:0] color;
    } stim_row_t;

    logic      clk_sdram;
    logic      reset_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    vid_out_t  vid;

    logic [31:0] lfsr_state;
    int          vs_seen;
    stim_row_t   table_rows [ROWS];

    video_core dut0 (
        .clk_sdram (clk_sdram),
        .reset_n   (reset_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .vid       (vid)
    );

    bind video_core video_core_assert assert0 (
        .clk_sdram (clk_sdram),
        .reset_n   (reset_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .vid       (vid)
    );

    initial clk_sdram = 1'b0;
    always #10 clk_sdram = ~clk_sdram;

    // vs pulses since reset
    always @(negedge clk_sdram) begin
        if (reset_n && vid.vs) begin
            vs_seen++;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic random_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // reference pixel, i within the line, n the active line
    function automatic pix_t expected_pixel(input logic [1:0] mode, input pix_t color,
                                            input int i, input int n);
        logic [2:0] bar;
        pix_t       p;
        bar = 3'(i / BAR_W);
        case (mode)
            2'd1: begin
                p.r = bar[0] ? 8'hff : 8'h00;
                p.g = bar[1] ? 8'hff : 8'h00;
                p.b = bar[2] ? 8'hff : 8'h00;
            end
            2'd2: begin
                p.r = 8'(i);
                p.g = 8'(n);
                p.b = 8'h00;
            end
            // solid, code 3 too
            default: p = color;
        endcase
        return p;
    endfunction

    task automatic expect_idle();
        assert (!wb_rsp.ack && !vid.de && !vid.vs && !vid.hs && vid.rgb == '0)
        else begin
            $display("CHECK FAILED idle outputs ack=%h de=%h vs=%h hs=%h rgb=%h",
                     wb_rsp.ack, vid.de, vid.vs, vid.hs, vid.rgb);
            abort_run();
        end
    endtask

    // one classic cycle, request held until ack
    task automatic bus_cycle(input logic we, input logic [7:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int   waited;
        logic got;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < ACK_TIMEOUT) begin
            @(negedge clk_sdram);
            waited++;
            got = wb_rsp.ack;
        end
        assert (got) else begin
            $display("no ack within %0d cycles for address %h", ACK_TIMEOUT, adr);
            abort_run();
        end
        rdat = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(negedge clk_sdram);
        // ack lasts one cycle only
        assert (!wb_rsp.ack) else begin
            $display("CHECK FAILED wb_rsp.ack got %h expected %h", wb_rsp.ack, 1'b0);
            abort_run();
        end
    endtask

    task automatic wait_for_vs();
        int waited;
        waited = 0;
        do begin
            @(negedge clk_sdram);
            waited++;
        end while (!vid.vs && waited < VS_TIMEOUT);
        assert (vid.vs) else begin
            $display("no vs within %0d cycles", VS_TIMEOUT);
            abort_run();
        end
    endtask

    // entered on a vs cycle, runs up to the next vs
    task automatic scan_frame(input logic [1:0] mode, input pix_t color);
        int   cycles;
        int   hs_count;
        int   de_lines;
        int   run_len;
        int   runs_since_hs;
        pix_t exp;
        cycles        = 0;
        hs_count      = 0;
        de_lines      = 0;
        run_len       = 0;
        runs_since_hs = 0;
        do begin
            @(negedge clk_sdram);
            cycles++;
            if (vid.hs) begin
                hs_count++;
                runs_since_hs = 0;
            end
            if (vid.de) begin
                if (run_len == 0) begin
                    assert (runs_since_hs == 0) else begin
                        $display("second de run on one line, line %0d", de_lines);
                        abort_run();
                    end
                    runs_since_hs = 1;
                end
                exp = expected_pixel(mode, color, run_len, de_lines);
                assert (vid.rgb == exp) else begin
                    $display("CHECK FAILED vid.rgb line %0d pixel %0d got %h expected %h",
                             de_lines, run_len, vid.rgb, exp);
                    abort_run();
                end
                run_len++;
            end else begin
                // blanking is black
                assert (vid.rgb == '0) else begin
                    $display("CHECK FAILED vid.rgb got %h expected %h", vid.rgb, 24'h0);
                    abort_run();
                end
                if (run_len != 0) begin
                    assert (run_len == `VID_H_ACTIVE) else begin
                        $display("CHECK FAILED vid.de run got %h expected %h",
                                 run_len, `VID_H_ACTIVE);
                        abort_run();
                    end
                    de_lines++;
                    run_len = 0;
                end
            end
        end while (!vid.vs && cycles < VS_TIMEOUT);
        assert (vid.vs) else begin
            $display("frame did not end with a vs within %0d cycles", VS_TIMEOUT);
            abort_run();
        end
        assert (cycles == FRAME_CYCLES && hs_count == `VID_V_TOTAL &&
                de_lines == `VID_V_ACTIVE)
        else begin
            $display("CHECK FAILED vid.vs period %h hs %h de lines %h expected %h %h %h",
                     cycles, hs_count, de_lines, FRAME_CYCLES, `VID_V_TOTAL,
                     `VID_V_ACTIVE);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          waited;
        logic [31:0] word;
        logic [31:0] rdat;
        logic [31:0] frames0;
        logic [31:0] frames1;
        int          vs_base;
        pix_t        color;

        wb_req     = '0;
        reset_n    = 1'b0;
        lfsr_state = 32'h6ac;
        vs_seen    = 0;

        table_rows[0] = '{mode: 2'd0, rand_color: 1'b1, color: 24'h0};
        table_rows[1] = '{mode: 2'd1, rand_color: 1'b0, color: 24'h0};
        table_rows[2] = '{mode: 2'd2, rand_color: 1'b0, color: 24'h0};
        // unused code, shows as solid
        table_rows[3] = '{mode: 2'd3, rand_color: 1'b1, color: 24'h0};

        repeat (2) begin
            @(negedge clk_sdram);
            expect_idle();
        end
        reset_n = 1'b1;

        // quiet outputs until the first frame starts
        waited = 0;
        do begin
            @(negedge clk_sdram);
            waited++;
            if (!vid.vs) begin
                expect_idle();
            end
        end while (!vid.vs && waited < VS_TIMEOUT);
        assert (vid.vs) else begin
            $display("no vs after reset within %0d cycles", VS_TIMEOUT);
            abort_run();
        end

        // register map readback, masked to the register widths
        random_bits(32, word);
        bus_cycle(1'b1, ADR_MODE, word, rdat);
        bus_cycle(1'b0, ADR_MODE, 32'h0, rdat);
        assert (rdat == (word & 32'h3)) else begin
            $display("CHECK FAILED mode got %h expected %h", rdat, word & 32'h3);
            abort_run();
        end
        random_bits(32, word);
        bus_cycle(1'b1, ADR_COLOR, word, rdat);
        bus_cycle(1'b0, ADR_COLOR, 32'h0, rdat);
        assert (rdat == (word & 32'h00ff_ffff)) else begin
            $display("CHECK FAILED color got %h expected %h", rdat, word & 32'h00ff_ffff);
            abort_run();
        end
        bus_cycle(1'b0, 8'h0c, 32'h0, rdat);
        assert (rdat == 32'h0) else begin
            $display("CHECK FAILED unmapped read got %h expected %h", rdat, 32'h0);
            abort_run();
        end

        // frame counter base, a write to it must be dropped
        bus_cycle(1'b0, ADR_FRAMES, 32'h0, frames0);
        vs_base = vs_seen;
        bus_cycle(1'b1, ADR_FRAMES, 32'hdead_beef, rdat);

        for (int r = 0; r < ROWS; r++) begin
            color = table_rows[r].color;
            if (table_rows[r].rand_color) begin
                random_bits(24, word);
                color = word[23:0];
            end
            bus_cycle(1'b1, ADR_MODE, {30'd0, table_rows[r].mode}, rdat);
            bus_cycle(1'b1, ADR_COLOR, {8'd0, color}, rdat);
            // settings land at the next frame start
            wait_for_vs();
            scan_frame(table_rows[r].mode, color);
        end

        // counter takes the last frame start at the end of the vs cycle
        @(negedge clk_sdram);
        bus_cycle(1'b0, ADR_FRAMES, 32'h0, frames1);
        assert (frames1 - frames0 == 32'(vs_seen - vs_base)) else begin
            $display("CHECK FAILED frames delta got %h expected %h",
                     frames1 - frames0, 32'(vs_seen - vs_base));
            abort_run();
        end

        if (dut0.assert0.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("bound port assertions failed %0d times", dut0.assert0.fail_count);
            abort_run();
        end
    end

endmodule

// File: video_core.f
+incdir+verilog
verilog/video_core_pkg.sv
verilog/video_timing.sv
verilog/line_buffer.sv
verilog/pattern_gen.sv
verilog/wb_regs.sv
verilog/video_core.sv
test/video_core_assert.sv
test/video_core_tb.sv

// File: Makefile
# Verilator build and run of the video core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = video_core_tb
FILELIST  = video_core.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
